// File: redmule_w_pkg.sv
// Weight staging definitions
package redmule_w_pkg;

  // FP16 element width
  localparam int unsigned BITW = 16;

  // Elements per beat, also the depth of the shift array
  localparam int unsigned D = 4;

  // Number of PE rows, also the height of the shift array
  localparam int unsigned H = 4;

  // Beat width
  localparam int unsigned DW = D * BITW;

  // One parity bit per byte of the beat
  localparam int unsigned PW = DW / 8;

  // Parity bits carried by each element
  localparam int unsigned PARW = PW / D;

  // Replicas of the control state
  localparam int unsigned REP = 3;

  // Pointer and leftover fields, wide enough to hold H or D
  localparam int unsigned ROWW = 3;
  localparam int unsigned COLW = 3;

  // One beat seen as FP16 elements for storage, or as bytes for parity
  typedef union packed {
    logic [D-1:0][BITW-1:0] elem;
    logic [PW-1:0][7:0]     byte_v;
  } w_beat_t;

endpackage

// File: tmr_voter.sv
// Triple majority voter
`timescale 1ns/10ps

module tmr_voter (
  input  logic [redmule_w_pkg::ROWW-1:0] a_i,
  input  logic [redmule_w_pkg::ROWW-1:0] b_i,
  input  logic [redmule_w_pkg::ROWW-1:0] c_i,
  output logic [redmule_w_pkg::ROWW-1:0] y_o,
  output logic                           mismatch_o
);

  // Per bit disagreement of each replica with the vote
  logic [redmule_w_pkg::ROWW-1:0] diff_a;
  logic [redmule_w_pkg::ROWW-1:0] diff_b;
  logic [redmule_w_pkg::ROWW-1:0] diff_c;

  // Bitwise two of three
  assign y_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // A single flipped replica still leaves the vote right
  assign diff_a = a_i ^ y_o;
  assign diff_b = b_i ^ y_o;
  assign diff_c = c_i ^ y_o;

  // Any replica off the vote is a fault
  assign mismatch_o = |(diff_a | diff_b | diff_c);

endmodule

// File: w_buffer_cfg.sv
// Triplicated leftover configuration
`timescale 1ns/10ps

module w_buffer_cfg (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           cfg_we_i,
  input  logic [redmule_w_pkg::ROWW-1:0] rows_lftovr_i,
  input  logic [redmule_w_pkg::COLW-1:0] cols_lftovr_i,
  output logic [redmule_w_pkg::ROWW-1:0] rows_lim_o,
  output logic [redmule_w_pkg::COLW-1:0] cols_lim_o,
  output logic                           fault_o
);

  import redmule_w_pkg::*;

  // Replicated leftover registers
  logic [REP-1:0][ROWW-1:0] rows_q;
  logic [REP-1:0][COLW-1:0] cols_q;

  // Voted leftovers and their disagreement flags
  logic [ROWW-1:0] rows_vot;
  logic [COLW-1:0] cols_vot;
  logic            rows_mis;
  logic            cols_mis;

  tmr_voter rows_voter_i (
    .a_i        (rows_q[0]),
    .b_i        (rows_q[1]),
    .c_i        (rows_q[2]),
    .y_o        (rows_vot),
    .mismatch_o (rows_mis)
  );

  tmr_voter cols_voter_i (
    .a_i        (cols_q[0]),
    .b_i        (cols_q[1]),
    .c_i        (cols_q[2]),
    .y_o        (cols_vot),
    .mismatch_o (cols_mis)
  );

  // Write all replicas together, otherwise scrub with the vote
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rows_q <= '0;
      cols_q <= '0;
    end else begin
      for (int r = 0; r < REP; r++) begin
        rows_q[r] <= cfg_we_i ? rows_lftovr_i : rows_vot;
        cols_q[r] <= cfg_we_i ? cols_lftovr_i : cols_vot;
      end
    end
  end

  // Zero leftover selects the full array
  assign rows_lim_o = (rows_vot == '0) ? ROWW'(H) : rows_vot;
  assign cols_lim_o = (cols_vot == '0) ? COLW'(D) : cols_vot;

  assign fault_o = rows_mis | cols_mis;

endmodule

// File: w_buffer.sv
// Weight shift array with parity
`timescale 1ns/10ps

module w_buffer (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic                                                     w_load_i,
  input  logic                                                     w_shift_i,
  input  logic                                                     w_clear_i,
  input  logic [redmule_w_pkg::ROWW-1:0]                           rows_lim_i,
  input  logic [redmule_w_pkg::COLW-1:0]                           cols_lim_i,
  input  redmule_w_pkg::w_beat_t                                   w_beat_i,
  input  logic [redmule_w_pkg::PW-1:0]                             w_parity_i,
  output logic [redmule_w_pkg::H-1:0][redmule_w_pkg::BITW-1:0]     w_col_o,
  output logic [redmule_w_pkg::H-1:0][redmule_w_pkg::PARW-1:0]     w_col_par_o,
  output logic                                                     fault_o
);

  import redmule_w_pkg::*;

  // Row pointer replicas and their next values
  logic [REP-1:0][ROWW-1:0] ptr_q;
  logic [REP-1:0][ROWW-1:0] ptr_nxt;
  logic [ROWW-1:0]          ptr_vot;
  logic [ROWW-1:0]          ptr_cur;
  logic                     row_ok;

  // Element and parity storage, depth slot 0 is the front column
  logic [D-1:0][H-1:0][BITW-1:0] w_q;
  logic [D-1:0][H-1:0][BITW-1:0] w_d;
  logic [D-1:0][H-1:0][PARW-1:0] p_q;
  logic [D-1:0][H-1:0][PARW-1:0] p_d;

  // Each replica steps on its own copy
  for (genvar r = 0; r < REP; r++) begin : gen_ptr_next
    always_comb begin
      if (w_clear_i) begin
        ptr_nxt[r] = '0;
      end else if (w_load_i) begin
        // Wrap after the last PE row
        ptr_nxt[r] = (ptr_q[r] == ROWW'(H - 1)) ? '0 : ptr_q[r] + ROWW'(1);
      end else begin
        ptr_nxt[r] = ptr_q[r];
      end
    end
  end

  // Vote before the register so every replica reloads the majority
  tmr_voter ptr_voter_i (
    .a_i        (ptr_nxt[0]),
    .b_i        (ptr_nxt[1]),
    .c_i        (ptr_nxt[2]),
    .y_o        (ptr_vot),
    .mismatch_o (fault_o)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else begin
      for (int r = 0; r < REP; r++) begin
        ptr_q[r] <= ptr_vot;
      end
    end
  end

  // Replicas agree after the vote, first one steers the datapath
  assign ptr_cur = ptr_q[0];
  assign row_ok  = ptr_cur < rows_lim_i;

  always_comb begin
    w_d = w_q;
    p_d = p_q;
    if (w_clear_i) begin
      w_d = '0;
      p_d = '0;
    end else if (w_load_i | w_shift_i) begin
      // Step along the depth, zeros enter at the back
      for (int d = 0; d < D - 1; d++) begin
        w_d[d] = w_q[d+1];
        p_d[d] = p_q[d+1];
      end
      w_d[D-1] = '0;
      p_d[D-1] = '0;
      // Load overwrites the pointed row in every slot
      if (w_load_i) begin
        for (int d = 0; d < D; d++) begin
          for (int h = 0; h < H; h++) begin
            if (ROWW'(h) == ptr_cur) begin
              if (row_ok && (COLW'(d) < cols_lim_i)) begin
                w_d[d][h] = w_beat_i.elem[d];
                p_d[d][h] = w_parity_i[d*PARW +: PARW];
              end else begin
                // Outside the leftover bounds
                w_d[d][h] = '0;
                p_d[d][h] = '0;
              end
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_q <= '0;
      p_q <= '0;
    end else begin
      w_q <= w_d;
      p_q <= p_d;
    end
  end

  assign w_col_o     = w_q[0];
  assign w_col_par_o = p_q[0];

endmodule

// File: w_parity_check.sv
// Front column parity checker
`timescale 1ns/10ps

module w_parity_check (
  input  logic [redmule_w_pkg::H-1:0][redmule_w_pkg::BITW-1:0] w_col_i,
  input  logic [redmule_w_pkg::H-1:0][redmule_w_pkg::PARW-1:0] w_col_par_i,
  output logic                                                 parity_err_o
);

  import redmule_w_pkg::*;

  // Column seen as a beat, H equals D here
  w_beat_t col_v;

  // Recomputed parity, bit 0 for the low byte and bit 1 for the high byte
  logic [H-1:0][PARW-1:0] par_exp;

  assign col_v = w_beat_t'(w_col_i);

  always_comb begin
    for (int h = 0; h < H; h++) begin
      par_exp[h][0] = ^col_v.byte_v[2*h];
      par_exp[h][1] = ^col_v.byte_v[2*h+1];
    end
  end

  // Any differing bit flags the column
  assign parity_err_o = |(par_exp ^ w_col_par_i);

endmodule

// File: w_stage_top.sv
// Weight staging top level
`timescale 1ns/10ps

module w_stage_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  logic                                                 cfg_we_i,
  input  logic [redmule_w_pkg::ROWW-1:0]                       rows_lftovr_i,
  input  logic [redmule_w_pkg::COLW-1:0]                       cols_lftovr_i,
  input  logic                                                 w_load_i,
  input  logic                                                 w_shift_i,
  input  logic                                                 w_clear_i,
  input  logic [redmule_w_pkg::DW-1:0]                         w_beat_i,
  input  logic [redmule_w_pkg::PW-1:0]                         w_parity_i,
  output logic [redmule_w_pkg::H-1:0][redmule_w_pkg::BITW-1:0] w_col_o,
  output logic [redmule_w_pkg::H-1:0][redmule_w_pkg::PARW-1:0] w_col_par_o,
  output logic                                                 parity_err_o,
  output logic                                                 fault_o
);

  import redmule_w_pkg::*;

  // Voted bounds from the configuration
  logic [ROWW-1:0] rows_lim;
  logic [COLW-1:0] cols_lim;

  // Fault sources and the internal column
  logic                   cfg_fault;
  logic                   ptr_fault;
  logic [H-1:0][BITW-1:0] w_col;
  logic [H-1:0][PARW-1:0] w_col_par;

  w_buffer_cfg w_buffer_cfg_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .rows_lftovr_i (rows_lftovr_i),
    .cols_lftovr_i (cols_lftovr_i),
    .rows_lim_o    (rows_lim),
    .cols_lim_o    (cols_lim),
    .fault_o       (cfg_fault)
  );

  w_buffer w_buffer_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .w_load_i    (w_load_i),
    .w_shift_i   (w_shift_i),
    .w_clear_i   (w_clear_i),
    .rows_lim_i  (rows_lim),
    .cols_lim_i  (cols_lim),
    .w_beat_i    (w_beat_t'(w_beat_i)),
    .w_parity_i  (w_parity_i),
    .w_col_o     (w_col),
    .w_col_par_o (w_col_par),
    .fault_o     (ptr_fault)
  );

  // Checks the registered front column
  w_parity_check w_parity_check_i (
    .w_col_i      (w_col),
    .w_col_par_i  (w_col_par),
    .parity_err_o (parity_err_o)
  );

  assign w_col_o     = w_col;
  assign w_col_par_o = w_col_par;

  // Either voter disagreeing is a fault
  assign fault_o = cfg_fault | ptr_fault;

endmodule

// File: w_stage_assertions.sv
// Weight staging output assertions
`timescale 1ns/10ps

module w_stage_assertions (
  input logic                                                 clk_i,
  input logic                                                 rst_n_i,
  input logic                                                 w_clear_i,
  input logic [redmule_w_pkg::H-1:0][redmule_w_pkg::BITW-1:0] w_col_o,
  input logic [redmule_w_pkg::H-1:0][redmule_w_pkg::PARW-1:0] w_col_par_o,
  input logic                                                 parity_err_o,
  input logic                                                 fault_o
);

  // Replicas never disagree without an upset
  fault_low: assert property (@(posedge clk_i) disable iff (!rst_n_i) !fault_o)
    else $error("fault flag raised");

  // First edge out of reset sees a clean column
  reset_clean: assert property (@(posedge clk_i) $rose(rst_n_i) |->
      (w_col_o == '0 && w_col_par_o == '0 && !parity_err_o && !fault_o))
    else $error("outputs not zero after reset");

  // Clear empties the front column on the next edge
  clear_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_clear_i |=> (w_col_o == '0 && w_col_par_o == '0))
    else $error("column not zero after clear");

endmodule

bind w_stage_top w_stage_assertions w_stage_assertions_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .w_clear_i    (w_clear_i),
  .w_col_o      (w_col_o),
  .w_col_par_o  (w_col_par_o),
  .parity_err_o (parity_err_o),
  .fault_o      (fault_o)
);

// File: tb_w_stage_top.sv
// Weight staging testbench
`timescale 1ns/10ps

module tb_w_stage_top;

  import redmule_w_pkg::*;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   cfg_we_i;
  logic [ROWW-1:0]        rows_lftovr_i;
  logic [COLW-1:0]        cols_lftovr_i;
  logic                   w_load_i;
  logic                   w_shift_i;
  logic                   w_clear_i;
  logic [DW-1:0]          w_beat_i;
  logic [PW-1:0]          w_parity_i;
  logic [H-1:0][BITW-1:0] w_col_o;
  logic [H-1:0][PARW-1:0] w_col_par_o;
  logic                   parity_err_o;
  logic                   fault_o;

  // Reference array, depth slot 0 is the front column
  logic [BITW-1:0] m_w [D][H];
  logic [PARW-1:0] m_p [D][H];
  int              m_ptr;
  int              m_rows;
  int              m_cols;

  w_stage_top w_stage_top_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cfg_we_i      (cfg_we_i),
    .rows_lftovr_i (rows_lftovr_i),
    .cols_lftovr_i (cols_lftovr_i),
    .w_load_i      (w_load_i),
    .w_shift_i     (w_shift_i),
    .w_clear_i     (w_clear_i),
    .w_beat_i      (w_beat_i),
    .w_parity_i    (w_parity_i),
    .w_col_o       (w_col_o),
    .w_col_par_o   (w_col_par_o),
    .parity_err_o  (parity_err_o),
    .fault_o       (fault_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v)
      stop_on_error($sformatf("[ERROR] %s expected %h actual %h", name, exp_v, act_v));
  endtask

  // Even parity, bit i covers byte i of the beat
  function automatic logic [PW-1:0] beat_parity(input logic [DW-1:0] beat);
    logic [PW-1:0] p;
    for (int i = 0; i < PW; i++)
      p[i] = ^beat[i*8 +: 8];
    return p;
  endfunction

  function automatic logic [DW-1:0] model_col();
    logic [DW-1:0] c;
    for (int h = 0; h < H; h++)
      c[h*BITW +: BITW] = m_w[0][h];
    return c;
  endfunction

  function automatic logic [PW-1:0] model_par();
    logic [PW-1:0] c;
    for (int h = 0; h < H; h++)
      c[h*PARW +: PARW] = m_p[0][h];
    return c;
  endfunction

  // Stored pair against the byte parity of the element
  function automatic logic model_perr();
    logic e;
    e = 1'b0;
    for (int h = 0; h < H; h++)
      e |= (m_p[0][h] != {^m_w[0][h][15:8], ^m_w[0][h][7:0]});
    return e;
  endfunction

  // Clear over load over shift, a load shifts first
  task automatic model_step(input logic ld, input logic sh, input logic cl,
                            input logic [DW-1:0] beat, input logic [PW-1:0] par);
    if (cl) begin
      for (int d = 0; d < D; d++)
        for (int h = 0; h < H; h++) begin
          m_w[d][h] = '0;
          m_p[d][h] = '0;
        end
      m_ptr = 0;
    end else if (ld || sh) begin
      for (int d = 0; d < D; d++)
        for (int h = 0; h < H; h++) begin
          m_w[d][h] = (d == D - 1) ? '0 : m_w[d+1][h];
          m_p[d][h] = (d == D - 1) ? '0 : m_p[d+1][h];
        end
      if (ld) begin
        for (int d = 0; d < D; d++) begin
          // Outside the leftovers the slot is zeroed
          m_w[d][m_ptr] = (m_ptr < m_rows && d < m_cols) ? beat[d*BITW +: BITW] : '0;
          m_p[d][m_ptr] = (m_ptr < m_rows && d < m_cols) ? par[d*PARW +: PARW] : '0;
        end
        m_ptr = (m_ptr == H - 1) ? 0 : m_ptr + 1;
      end
    end
  endtask

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic compare_outputs(input string name);
    check_val({name, " col"}, model_col(), w_col_o);
    check_val({name, " par"}, 64'(model_par()), 64'(w_col_par_o));
    check_val({name, " perr"}, 64'(model_perr()), 64'(parity_err_o));
    check_val({name, " fault"}, 64'(0), 64'(fault_o));
  endtask

  // One strobe cycle, the column is checked one edge later
  task automatic strobe(input string name, input logic ld, input logic sh, input logic cl,
                        input logic [DW-1:0] beat, input logic [PW-1:0] par);
    w_load_i   = ld;
    w_shift_i  = sh;
    w_clear_i  = cl;
    w_beat_i   = beat;
    w_parity_i = par;
    model_step(ld, sh, cl, beat, par);
    tick();
    w_load_i  = 1'b0;
    w_shift_i = 1'b0;
    w_clear_i = 1'b0;
    compare_outputs(name);
  endtask

  // Zero leftover stands for the full size
  task automatic configure(input int rows, input int cols);
    cfg_we_i      = 1'b1;
    rows_lftovr_i = ROWW'(rows);
    cols_lftovr_i = COLW'(cols);
    tick();
    cfg_we_i = 1'b0;
    m_rows   = (rows == 0) ? H : rows;
    m_cols   = (cols == 0) ? D : cols;
  endtask

  initial begin
    logic [DW-1:0] beat;
    logic [PW-1:0] par;
    logic          ld;
    int            n_bad;
    int            tries;
    void'($urandom(49189));
    rst_n_i       = 1'b0;
    cfg_we_i      = 1'b0;
    rows_lftovr_i = '0;
    cols_lftovr_i = '0;
    w_load_i      = 1'b0;
    w_shift_i     = 1'b0;
    w_clear_i     = 1'b0;
    w_beat_i      = '0;
    w_parity_i    = '0;
    model_step(1'b0, 1'b0, 1'b1, '0, '0);
    m_rows = H;
    m_cols = D;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    compare_outputs("reset");

    // Full bounds stream, pointer wraps many times
    for (int i = 0; i < 64; i++) begin
      beat = {$urandom, $urandom};
      ld   = $urandom_range(1, 0) != 0;
      strobe("stream", ld, !ld, 1'b0, beat, beat_parity(beat));
    end

    // Random nonzero leftovers, each on a fresh array
    for (int r = 0; r < 6; r++) begin
      configure($urandom_range(H, 1), $urandom_range(D, 1));
      strobe("bounds clear", 1'b0, 1'b0, 1'b1, beat, beat_parity(beat));
      for (int i = 0; i < H + D; i++) begin
        beat = {$urandom, $urandom};
        strobe("bounds", i < H, i >= H, 1'b0, beat, beat_parity(beat));
      end
    end
    configure(0, 0);

    // Low byte parity of element 0 flipped, lands in the front column
    strobe("parity clear", 1'b0, 1'b0, 1'b1, beat, beat_parity(beat));
    beat = {$urandom, $urandom};
    strobe("parity flip", 1'b1, 1'b0, 1'b0, beat, beat_parity(beat) ^ PW'(1));
    check_val("parity flip flag", 64'(1), 64'(parity_err_o));
    n_bad = 0;
    for (int i = 0; i < 48; i++) begin
      beat = {$urandom, $urandom};
      par  = beat_parity(beat);
      if ($urandom_range(3, 0) == 0)
        par = par ^ (PW'(1) << $urandom_range(PW - 1, 0));
      ld = $urandom_range(1, 0) != 0;
      strobe("parity stream", ld, !ld, 1'b0, beat, par);
      if (parity_err_o)
        n_bad++;
    end
    if (n_bad == 0)
      stop_on_error("No corrupted element reached the front column");
    // Shift until the flag drops
    tries = 0;
    while (parity_err_o && tries < D + 1) begin
      strobe("parity drain", 1'b0, 1'b1, 1'b0, beat, par);
      tries++;
    end
    if (parity_err_o)
      stop_on_error("Timeout waiting for the parity error to clear");

    // Clear in mid stream, also against a load in the same cycle
    for (int i = 0; i < 3; i++) begin
      beat = {$urandom, $urandom};
      strobe("pre clear", 1'b1, 1'b0, 1'b0, beat, beat_parity(beat));
    end
    strobe("clear over load", 1'b1, 1'b1, 1'b1, beat, beat_parity(beat));
    beat = {$urandom, $urandom};
    strobe("after clear", 1'b1, 1'b0, 1'b0, beat, beat_parity(beat));
    check_val("row 0 after clear", 64'(beat[BITW-1:0]), 64'(w_col_o[0]));

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: w_stage_top.f
redmule_w_pkg.sv
tmr_voter.sv
w_buffer_cfg.sv
w_buffer.sv
w_parity_check.sv
w_stage_top.sv
w_stage_assertions.sv
tb_w_stage_top.sv

// File: Makefile
TOP = tb_w_stage_top

.PHONY: all lint clean

# Build, run and look for the pass line in the output
all:
	verilator --binary --timing --assert -f w_stage_top.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only -Wall --timing -f w_stage_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir
